/* project.f */
source/lc3b_isa_pkg.sv
source/lc3b_ctrl_pkg.sv
source/lc3b_decode.sv
source/lc3b_regfile.sv
source/lc3b_execute.sv
source/lc3b_writeback.sv
source/lc3b_backend.sv
test/lc3b_backend_properties.sv
test/tb_lc3b_backend.sv

/* Bender.yml */
package:
  name: lc3b_backend

sources:
  # Packages before the modules that import them
  - source/lc3b_isa_pkg.sv
  - source/lc3b_ctrl_pkg.sv
  - source/lc3b_decode.sv
  - source/lc3b_regfile.sv
  - source/lc3b_execute.sv
  - source/lc3b_writeback.sv
  - source/lc3b_backend.sv
  - target: test
    files:
      - test/lc3b_backend_properties.sv
      - test/tb_lc3b_backend.sv

/* test/tb_lc3b_backend.sv */
`timescale 1ns/100ps

module tb_lc3b_backend;

    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    // Strobes expected in one cycle
    typedef struct packed {
        logic [31:0] due;
        logic        wb_valid;
        lc3b_wb_rec  wb;
        logic        mem_valid;
        lc3b_word    mem_addr;
        logic        branch_taken;
        lc3b_word    branch_target;
    } exp_slot;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    lc3b_word    instr;
    lc3b_word    npc_in;
    logic        wb_valid;
    lc3b_wb_rec  wb;
    logic        mem_valid;
    lc3b_word    mem_addr;
    logic        branch_taken;
    lc3b_word    branch_target;
    logic        branch_stall;

    // Reference model state
    lc3b_word    model_regs [8];
    lc3b_nzp     model_cc;
    lc3b_word    pc;
    logic [31:0] rng_state;
    int unsigned cycle;
    exp_slot     late_q [$];
    int unsigned stall_q [$];   // Cycles with branch_stall high

    lc3b_opcode supported_ops [12] = '{op_add, op_and, op_not, op_shf, op_lea, op_br,
                                       op_jmp, op_ldr, op_str, op_ldb, op_stb, op_ldi};
    lc3b_opcode unsupported_ops [4] = '{op_jsr, op_rti, op_sti, op_trap};

    lc3b_backend i_dut (
        .clk, .arst_n, .instr_valid, .instr, .npc_in,
        .wb_valid, .wb, .mem_valid, .mem_addr,
        .branch_taken, .branch_target, .branch_stall
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic lc3b_word sext_bits(input lc3b_word field, input int width);
        lc3b_word mask;
        mask = 16'hffff << width;
        return field[width - 1] ? (field | mask) : (field & ~mask);
    endfunction

    function automatic lc3b_nzp flags_of(input lc3b_word value);
        if (value == 16'h0000)
            return 3'b010;
        return value[15] ? 3'b100 : 3'b001;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic compare_wb(input string name, input lc3b_wb_rec got, input lc3b_wb_rec exp);
        if (got !== exp)
            report_failure($sformatf(
                "** Error: %s dr %h data %h cc %h, expected dr %h data %h cc %h",
                name, got.dr, got.data, got.cc, exp.dr, exp.data, exp.cc));
    endtask

    task automatic compare_word(input string name, input lc3b_word got, input lc3b_word exp);
        if (got !== exp)
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_nzp(input string name, input lc3b_nzp got, input lc3b_nzp exp);
        if (got !== exp)
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model

    task automatic run_model(input lc3b_word ins, input lc3b_word npc,
                             output exp_slot slot, output logic stall);
        lc3b_word a;
        lc3b_word b;
        lc3b_word value;
        logic     write;
        logic     set_cc;
        a      = model_regs[ins[8:6]];
        b      = ins[5] ? sext_bits(ins, 5) : model_regs[ins[2:0]];
        slot   = '0;
        stall  = 1'b0;
        value  = '0;
        write  = 1'b1;
        set_cc = 1'b1;
        case (lc3b_opcode'(ins[15:12]))
            op_add: value = a + b;
            op_and: value = a & b;
            op_not: value = ~a;
            op_shf: begin
                if (!ins[4])
                    value = a << ins[3:0];
                else if (!ins[5])
                    value = a >> ins[3:0];
                else
                    value = lc3b_word'($signed(a) >>> ins[3:0]);
            end
            op_lea: begin
                value  = npc + (sext_bits(ins, 9) << 1);
                set_cc = 1'b0;
            end
            op_br, op_jmp: begin
                write = 1'b0;
                stall = 1'b1;
                if (ins[15:12] == op_jmp) begin
                    slot.branch_taken  = 1'b1;
                    slot.branch_target = a;
                end else begin
                    slot.branch_taken  = |(ins[11:9] & model_cc);
                    slot.branch_target = npc + (sext_bits(ins, 9) << 1);
                end
            end
            op_ldr, op_str, op_ldb, op_stb, op_ldi: begin
                write          = 1'b0;
                slot.mem_valid = 1'b1;
                slot.mem_addr  = a + (sext_bits(ins, 6) << 1);
            end
            default: write = 1'b0;   // Bubble
        endcase
        if (write) begin
            slot.wb_valid            = 1'b1;
            slot.wb                  = '{dr: ins[11:9], data: value, cc: flags_of(value)};
            model_regs[ins[11:9]]    = value;
            if (set_cc)
                model_cc = flags_of(value);
        end
    endtask

    // One instruction slot driven after the edge
    task automatic issue(input logic valid, input lc3b_word ins);
        exp_slot slot;
        logic    stall;
        @(posedge clk);
        #10;
        pc          = pc + 16'd2;
        instr_valid = valid;
        instr       = ins;
        npc_in      = pc;
        if (valid) begin
            run_model(ins, pc, slot, stall);
            slot.due = cycle + 3;
            late_q.push_back(slot);
            if (stall)
                stall_q.push_back(cycle + 1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Output checker

    always @(negedge clk) begin
        exp_slot slot;
        logic    stall_exp;
        slot      = '0;
        stall_exp = 1'b0;
        if (i_dut.i_properties.fail_count != 0)
            report_failure("A bound assertion failed");
        if (arst_n) begin
            if (late_q.size() != 0 && late_q[0].due == cycle)
                slot = late_q.pop_front();
            if (stall_q.size() != 0 && stall_q[0] == cycle) begin
                stall_exp = 1'b1;
                void'(stall_q.pop_front());
            end
            compare_bit("wb_valid", wb_valid, slot.wb_valid);
            if (slot.wb_valid)
                compare_wb("wb", wb, slot.wb);
            compare_bit("mem_valid", mem_valid, slot.mem_valid);
            if (slot.mem_valid)
                compare_word("mem_addr", mem_addr, slot.mem_addr);
            compare_bit("branch_taken", branch_taken, slot.branch_taken);
            if (slot.branch_taken)
                compare_word("branch_target", branch_target, slot.branch_target);
            compare_bit("branch_stall", branch_stall, stall_exp);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus

    initial begin
        lc3b_word    directed [12];
        lc3b_word    ins;
        logic [31:0] r;
        int          wait_count;
        directed = '{16'h1225, 16'h147d, 16'h1242, 16'h967f,   // Dependent chain
                     16'h58c1, 16'hea04, 16'h05fe, 16'h0a03,   // AND to zero, LEA, BRz, BRnp
                     16'hdc43, 16'hc180, 16'h61bf, 16'hdef2};  // LSHF, JMP, LDR, RSHFA
        arst_n      = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        npc_in      = '0;
        model_regs  = '{default: '0};
        model_cc    = '0;
        pc          = 16'h3000;
        rng_state   = 32'h1e5a37c8;
        #1 arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #10 arst_n = 1'b1;

        foreach (directed[i])
            issue(1'b1, directed[i]);

        repeat (600) begin
            r = next_rand();
            if (r[31:29] == 3'd0) begin
                issue(1'b0, r[15:0]);                    // Idle with junk on instr
            end else if (r[31:28] == 4'd2) begin
                issue(1'b1, {unsupported_ops[r[17:16]], r[11:0]});
            end else begin
                ins = {supported_ops[r[27:20] % 12], r[11:0]};
                if (r[18]) begin
                    ins[11] = 1'b0;   // Only r0 to r3 for more dependencies
                    ins[8]  = 1'b0;
                    ins[2]  = 1'b0;
                end
                issue(1'b1, ins);
            end
        end

        @(posedge clk);
        #10 instr_valid = 1'b0;
        wait_count = 0;
        while (late_q.size() != 0 || stall_q.size() != 0) begin
            if (wait_count == 10)
                report_failure("Timed out waiting for the last expected strobes");
            @(posedge clk);
            wait_count++;
        end
        repeat (3) begin
            r = next_rand();
            issue(1'b0, r[15:0]);
        end

        for (int i = 0; i < 8; i++)
            compare_word($sformatf("r%0d", i), i_dut.i_regfile.regs[i], model_regs[i]);
        compare_nzp("cc", i_dut.rf_cc, model_cc);

        if (i_dut.i_properties.fail_count != 0) begin
            report_failure("A bound assertion failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* test/lc3b_backend_properties.sv */
`timescale 1ns/100ps

module lc3b_backend_properties (
    input logic clk,
    input logic arst_n,
    input logic wb_valid,
    input logic mem_valid,
    input logic branch_taken,
    input logic branch_stall
);

    int unsigned fail_count;   // Failed assertions so far

    // Reset holds every strobe low
    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !(wb_valid || mem_valid || branch_taken || branch_stall))
        else begin
            fail_count++;
            $error("Strobe high while reset is asserted");
        end

    taken_after_stall: assert property (@(posedge clk) disable iff (!arst_n)
        branch_taken |-> $past(branch_stall, 2))   // Branch sat in execute two cycles back
        else begin
            fail_count++;
            $error("branch_taken without branch_stall two cycles earlier");
        end

    // Loads and stores write no register
    mem_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        mem_valid |-> !wb_valid)
        else begin
            fail_count++;
            $error("mem_valid and wb_valid high in the same cycle");
        end

endmodule

bind lc3b_backend lc3b_backend_properties i_properties (
    .clk, .arst_n, .wb_valid, .mem_valid, .branch_taken, .branch_stall
);

/* source/lc3b_backend.sv */
`timescale 1ns/100ps

module lc3b_backend (
    input  logic                      clk,
    input  logic                      arst_n,

    input  logic                      instr_valid,
    input  lc3b_isa_pkg::lc3b_word    instr,
    input  lc3b_isa_pkg::lc3b_word    npc_in,

    output logic                      wb_valid,
    output lc3b_ctrl_pkg::lc3b_wb_rec wb,
    output logic                      mem_valid,
    output lc3b_isa_pkg::lc3b_word    mem_addr,
    output logic                      branch_taken,
    output lc3b_isa_pkg::lc3b_word    branch_target,
    output logic                      branch_stall
);

    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    // Register file ports
    lc3b_reg          rf_sr1_idx;
    lc3b_reg          rf_sr2_idx;
    lc3b_word         rf_sr1;
    lc3b_word         rf_sr2;
    lc3b_nzp          rf_cc;
    logic             wb_load_cc;

    // Decode to execute
    lc3b_control_word de_cw;
    lc3b_word         de_ir;
    lc3b_word         de_npc;
    lc3b_word         de_sr1;
    lc3b_word         de_sr2;
    lc3b_nzp          de_cc;
    lc3b_reg          de_dr;
    logic             de_valid;

    lc3b_ex_rec       ex;

    lc3b_decode i_decode (
        .clk, .arst_n, .instr_valid, .instr, .npc_in,
        .rf_sr1_idx, .rf_sr2_idx, .rf_sr1, .rf_sr2, .rf_cc,
        .ex_fwd (ex),
        .cw (de_cw), .ir (de_ir), .npc (de_npc), .sr1 (de_sr1), .sr2 (de_sr2),
        .cc (de_cc), .dr (de_dr), .valid (de_valid)
    );

    lc3b_regfile i_regfile (
        .clk, .arst_n,
        .sr1_idx (rf_sr1_idx), .sr2_idx (rf_sr2_idx),
        .sr1 (rf_sr1), .sr2 (rf_sr2), .cc (rf_cc),
        .wb_valid, .wb, .load_cc (wb_load_cc)
    );

    lc3b_execute i_execute (
        .clk, .arst_n,
        .cw (de_cw), .ir (de_ir), .npc (de_npc), .sr1 (de_sr1), .sr2 (de_sr2),
        .cc (de_cc), .dr (de_dr), .valid (de_valid),
        .ex,
        .ex_load_cc (), .ex_load_regfile (),   // Carried inside the record
        .ex_branch_stall (branch_stall)
    );

    lc3b_writeback i_writeback (
        .clk, .arst_n, .ex,
        .wb_valid, .wb, .load_cc (wb_load_cc),
        .mem_valid, .mem_addr, .branch_taken, .branch_target
    );

endmodule

/* source/lc3b_writeback.sv */
`timescale 1ns/100ps

module lc3b_writeback (
    input  logic                      clk,
    input  logic                      arst_n,

    input  lc3b_ctrl_pkg::lc3b_ex_rec ex,

    output logic                      wb_valid,
    output lc3b_ctrl_pkg::lc3b_wb_rec wb,
    output logic                      load_cc,
    output logic                      mem_valid,
    output lc3b_isa_pkg::lc3b_word    mem_addr,
    output logic                      branch_taken,
    output lc3b_isa_pkg::lc3b_word    branch_target
);

    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    lc3b_word data;
    logic     taken;

    assign data = ex_rec_data(ex);

    // ~~~~~~~~~~~~~~~~~~~~
    // Branch evaluation

    always_comb begin
        taken = 1'b0;
        if (ex.valid && ex.cw.is_branch) begin
            if (lc3b_opcode'(ex.ir[15:12]) == op_jmp)
                taken = 1'b1;
            else
                taken = |(ex.ir[11:9] & ex.cc);   // nzp mask against flags
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output strobes

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid     <= 1'b0;
            load_cc      <= 1'b0;
            mem_valid    <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            wb_valid     <= ex.cw.load_regfile;   // Already valid-gated
            load_cc      <= ex.cw.load_cc;
            mem_valid    <= ex.valid & ex.cw.is_mem;
            branch_taken <= taken;
        end
    end

    always_ff @(posedge clk) begin
        wb            <= '{dr: ex.dr, data: data, cc: gen_nzp(data)};
        mem_addr      <= ex.address;
        branch_target <= ex.address;
    end

endmodule

/* source/lc3b_execute.sv */
`timescale 1ns/100ps

module lc3b_execute (
    input  logic                            clk,
    input  logic                            arst_n,

    input  lc3b_ctrl_pkg::lc3b_control_word cw,
    input  lc3b_isa_pkg::lc3b_word          ir,
    input  lc3b_isa_pkg::lc3b_word          npc,
    input  lc3b_isa_pkg::lc3b_word          sr1,
    input  lc3b_isa_pkg::lc3b_word          sr2,
    input  lc3b_isa_pkg::lc3b_nzp           cc,
    input  lc3b_isa_pkg::lc3b_reg           dr,
    input  logic                            valid,

    output lc3b_ctrl_pkg::lc3b_ex_rec       ex,
    output logic                            ex_load_cc,
    output logic                            ex_load_regfile,
    output logic                            ex_branch_stall
);

    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    lc3b_word         addr1;
    lc3b_word         addr2;
    lc3b_word         trap_vec;
    lc3b_word         address;
    lc3b_word         alu_b;
    lc3b_word         result;
    lc3b_control_word cw_gated;

    // Registered record
    lc3b_control_word cw_q;
    logic             valid_q;
    lc3b_reg          dr_q;
    lc3b_word         npc_q;
    lc3b_word         ir_q;
    lc3b_word         result_q;
    lc3b_word         address_q;
    lc3b_nzp          cc_q;

    // Sign-extend the low width bits of field
    function automatic lc3b_word sext(input lc3b_word field, input int unsigned width);
        logic signed [15:0] top;
        top = field << (16 - width);
        return lc3b_word'(top >>> (16 - width));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Address arithmetic

    assign addr1    = cw.addr1mux_sel ? sr1 : npc;
    assign trap_vec = {7'b0, ir[7:0], 1'b0};

    always_comb begin
        case (cw.addr2mux_sel)
            addr2_off6:  addr2 = sext(ir, 6) << 1;
            addr2_off9:  addr2 = sext(ir, 9) << 1;
            addr2_off11: addr2 = sext(ir, 11) << 1;
            default:     addr2 = '0;
        endcase
    end

    assign address = cw.memaddrmux_sel ? trap_vec : lc3b_word'(addr1 + addr2);

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU

    assign alu_b = cw.sr2mux_sel ? sext(ir, 5) : sr2;

    always_comb begin
        case (cw.aluop)
            alu_add: result = sr1 + alu_b;
            alu_and: result = sr1 & alu_b;
            alu_not: result = ~sr1;
            alu_sll: result = sr1 << alu_b[3:0];
            alu_srl: result = sr1 >> alu_b[3:0];
            alu_sra: result = lc3b_word'($signed(sr1) >>> alu_b[3:0]);
            default: result = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Valid gating and stage register

    assign ex_load_cc      = valid & cw.load_cc;
    assign ex_load_regfile = valid & cw.load_regfile;
    assign ex_branch_stall = valid & cw.branch_stall;

    always_comb begin
        cw_gated              = cw;
        cw_gated.load_cc      = ex_load_cc;
        cw_gated.load_regfile = ex_load_regfile;
        cw_gated.branch_stall = ex_branch_stall;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            cw_q    <= '0;
        end else begin
            valid_q <= valid;
            cw_q    <= cw_gated;
        end
    end

    always_ff @(posedge clk) begin
        dr_q      <= dr;
        npc_q     <= npc;
        ir_q      <= ir;
        result_q  <= result;
        address_q <= address;
        cc_q      <= cc;   // Flags seen by a BR
    end

    assign ex = '{cw: cw_q, dr: dr_q, npc: npc_q, ir: ir_q, result: result_q,
                  address: address_q, cc: cc_q, valid: valid_q};

endmodule

/* source/lc3b_regfile.sv */
`timescale 1ns/100ps

module lc3b_regfile (
    input  logic                      clk,
    input  logic                      arst_n,

    input  lc3b_isa_pkg::lc3b_reg     sr1_idx,
    input  lc3b_isa_pkg::lc3b_reg     sr2_idx,
    output lc3b_isa_pkg::lc3b_word    sr1,
    output lc3b_isa_pkg::lc3b_word    sr2,
    output lc3b_isa_pkg::lc3b_nzp     cc,

    input  logic                      wb_valid,
    input  lc3b_ctrl_pkg::lc3b_wb_rec wb,
    input  logic                      load_cc
);

    import lc3b_isa_pkg::*;

    lc3b_word regs [8];
    lc3b_nzp  cc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
            cc_q <= '0;
        end else begin
            if (wb_valid)
                regs[wb.dr] <= wb.data;
            if (load_cc)
                cc_q <= wb.cc;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign sr1 = (wb_valid && wb.dr == sr1_idx) ? wb.data : regs[sr1_idx];
    assign sr2 = (wb_valid && wb.dr == sr2_idx) ? wb.data : regs[sr2_idx];
    assign cc  = load_cc ? wb.cc : cc_q;

endmodule

/* source/lc3b_decode.sv */
`timescale 1ns/100ps

module lc3b_decode (
    input  logic                           clk,
    input  logic                           arst_n,

    input  logic                           instr_valid,
    input  lc3b_isa_pkg::lc3b_word         instr,
    input  lc3b_isa_pkg::lc3b_word         npc_in,

    output lc3b_isa_pkg::lc3b_reg          rf_sr1_idx,
    output lc3b_isa_pkg::lc3b_reg          rf_sr2_idx,
    input  lc3b_isa_pkg::lc3b_word         rf_sr1,
    input  lc3b_isa_pkg::lc3b_word         rf_sr2,
    input  lc3b_isa_pkg::lc3b_nzp          rf_cc,

    input  lc3b_ctrl_pkg::lc3b_ex_rec      ex_fwd,

    output lc3b_ctrl_pkg::lc3b_control_word cw,
    output lc3b_isa_pkg::lc3b_word         ir,
    output lc3b_isa_pkg::lc3b_word         npc,
    output lc3b_isa_pkg::lc3b_word         sr1,
    output lc3b_isa_pkg::lc3b_word         sr2,
    output lc3b_isa_pkg::lc3b_nzp          cc,
    output lc3b_isa_pkg::lc3b_reg          dr,
    output logic                           valid
);

    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    lc3b_control_word cw_next;
    logic             supported;
    lc3b_word         fwd_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // Opcode decode

    always_comb begin
        cw_next   = '0;
        supported = 1'b1;
        case (lc3b_opcode'(instr[15:12]))
            op_add, op_and: begin
                cw_next.aluop        = (instr[15:12] == op_add) ? alu_add : alu_and;
                cw_next.sr2mux_sel   = instr[5];   // Immediate form
                cw_next.load_cc      = 1'b1;
                cw_next.load_regfile = 1'b1;
            end
            op_not: begin
                cw_next.aluop        = alu_not;
                cw_next.load_cc      = 1'b1;
                cw_next.load_regfile = 1'b1;
            end
            op_shf: begin
                if (!instr[4])
                    cw_next.aluop = alu_sll;
                else if (!instr[5])
                    cw_next.aluop = alu_srl;
                else
                    cw_next.aluop = alu_sra;
                cw_next.sr2mux_sel   = 1'b1;       // Shift count from imm4
                cw_next.load_cc      = 1'b1;
                cw_next.load_regfile = 1'b1;
            end
            op_lea: begin
                cw_next.addr2mux_sel = addr2_off9;
                cw_next.result_sel   = 1'b1;
                cw_next.load_regfile = 1'b1;       // cc untouched
            end
            op_br: begin
                cw_next.addr2mux_sel = addr2_off9;
                cw_next.branch_stall = 1'b1;
                cw_next.is_branch    = 1'b1;
            end
            op_jmp: begin
                cw_next.addr1mux_sel = 1'b1;
                cw_next.addr2mux_sel = addr2_zero;
                cw_next.branch_stall = 1'b1;
                cw_next.is_branch    = 1'b1;
            end
            op_ldr, op_str, op_ldb, op_stb, op_ldi: begin
                cw_next.addr1mux_sel = 1'b1;
                cw_next.addr2mux_sel = addr2_off6;
                cw_next.is_mem       = 1'b1;
            end
            default: supported = 1'b0;             // Retires as a bubble
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            cw    <= '0;
        end else begin
            valid <= instr_valid & supported;
            cw    <= cw_next;
        end
    end

    always_ff @(posedge clk) begin
        ir  <= instr;
        npc <= npc_in;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Operand fetch

    // BR carries offset bits where a base register would sit
    assign rf_sr1_idx = (lc3b_opcode'(ir[15:12]) == op_br) ? 3'd0 : ir[8:6];
    assign rf_sr2_idx = ir[2:0];
    assign dr         = ir[11:9];

    assign fwd_data = ex_rec_data(ex_fwd);

    // Instruction one ahead overrides the register file
    assign sr1 = (ex_fwd.cw.load_regfile && ex_fwd.dr == rf_sr1_idx) ? fwd_data : rf_sr1;
    assign sr2 = (ex_fwd.cw.load_regfile && ex_fwd.dr == rf_sr2_idx) ? fwd_data : rf_sr2;
    assign cc  = ex_fwd.cw.load_cc ? gen_nzp(fwd_data) : rf_cc;

endmodule

/* source/lc3b_ctrl_pkg.sv */
package lc3b_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef enum logic [1:0] {
        addr2_zero,
        addr2_off6,
        addr2_off9,
        addr2_off11
    } lc3b_addr2_sel;

    typedef struct packed {
        lc3b_aluop     aluop;
        logic          addr1mux_sel;     // 0 next PC, 1 sr1
        lc3b_addr2_sel addr2mux_sel;
        logic          sr2mux_sel;       // 0 register, 1 imm5
        logic          memaddrmux_sel;   // 1 trap vector
        logic          load_cc;
        logic          load_regfile;
        logic          branch_stall;
        logic          result_sel;       // 1 address, for LEA
        logic          is_branch;
        logic          is_mem;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_control_word      cw;
        lc3b_isa_pkg::lc3b_reg dr;
        lc3b_isa_pkg::lc3b_word npc;
        lc3b_isa_pkg::lc3b_word ir;
        lc3b_isa_pkg::lc3b_word result;
        lc3b_isa_pkg::lc3b_word address;
        lc3b_isa_pkg::lc3b_nzp cc;
        logic                  valid;
    } lc3b_ex_rec;

    typedef struct packed {
        lc3b_isa_pkg::lc3b_reg  dr;
        lc3b_isa_pkg::lc3b_word data;
        lc3b_isa_pkg::lc3b_nzp  cc;
    } lc3b_wb_rec;

    // Register write value carried by an execute record
    function automatic lc3b_isa_pkg::lc3b_word ex_rec_data(input lc3b_ex_rec rec);
        return rec.cw.result_sel ? rec.address : rec.result;
    endfunction

endpackage

/* source/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;   // n, z, p from msb down

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // Condition codes of a value written to a register
    function automatic lc3b_nzp gen_nzp(input lc3b_word value);
        if (value[15])
            return 3'b100;
        return (value == '0) ? 3'b010 : 3'b001;
    endfunction

endpackage
